/* spi_io_pkg.sv */
package spi_io_pkg;

    // --------------------
    // Basic types
    // --------------------

    // One data byte, as held in both buffers and the shift registers
    typedef logic [7:0] byte_t;

    // Transfer FSM states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,   // Waiting for send, host owns the buffers
        LOAD  = 3'd1,   // First byte goes into the shifter, cs_n drops
        SHIFT = 3'd2,   // Eight SPI clocks in flight
        NEXT  = 3'd3,   // Following byte goes into the shifter
        DONE  = 3'd4    // One-cycle end pulse, cs_n back high
    } io_state_e;

    // --------------------
    // Bundles
    // --------------------

    // Master-side SPI pins
    typedef struct packed {
        logic sclk;     // SPI clock, idles low (mode 0)
        logic mosi;     // Master out, MSB first
        logic cs_n;     // Chip select, low for the whole transfer
    } spi_pins_t;

    // SPI clock edge strobes from the timer
    // Each field is high for a single sysClk cycle
    typedef struct packed {
        logic rise;     // sclk goes high, miso is sampled
        logic fall;     // sclk goes low, mosi moves on
    } spi_tick_t;

endpackage

/* spi_io_buffer.sv */
module spi_io_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                                                  sysClk,
    input  logic                                                  wr_n_i,  // Write strobe
    input  logic                                                  rd_n_i,  // Read strobe
    input  logic [((BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1)-1:0]  addr_i,
    input  spi_io_pkg::byte_t                                     data_i,
    output spi_io_pkg::byte_t                                     data_o   // Valid a cycle after rd
);

    spi_io_pkg::byte_t mem [BUF_DEPTH];   // Byte storage

    // Single port, write and registered read share the address
    always_ff @(posedge sysClk) begin
        if (!wr_n_i) begin
            mem[addr_i] <= data_i;
        end
        if (!rd_n_i) begin
            data_o <= mem[addr_i];        // Holds its value between reads
        end
    end

    // Writes must stay inside the array, also for depths that are not a power of two
    a_wr_in_range : assert property (
        @(posedge sysClk) !wr_n_i |-> (32'(addr_i) < BUF_DEPTH)
    ) else $error("buffer write out of range, addr %0d", addr_i);

    // Reads the same way
    a_rd_in_range : assert property (
        @(posedge sysClk) !rd_n_i |-> (32'(addr_i) < BUF_DEPTH)
    ) else $error("buffer read out of range, addr %0d", addr_i);

endmodule

/* spi_clk_timer.sv */
module spi_clk_timer #(
    parameter int CLK_DIV = 2   // sysClk cycles per SPI half-period
) (
    input  logic                  sysClk,
    input  logic                  reset,       // Sync, active low
    input  logic                  run_i,       // Count while high, clear while low
    output spi_io_pkg::spi_tick_t tick_o,      // Rise/fall strobes
    output logic                  byte_end_o   // With the eighth fall
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    // --------------------
    // Counters
    // --------------------
    logic [CNT_W-1:0] half_q;     // sysClk cycles within a half-period
    logic [3:0]       edge_q;     // Half-edges within the byte, even = rise
    logic             half_end;   // Last cycle of a half-period

    // Stop at byte_end so a divider of 1 does not start the next byte early
    assign half_end = run_i && !byte_end_o && (half_q == CNT_W'(CLK_DIV - 1));

    always_ff @(posedge sysClk) begin
        if (!reset) begin
            half_q     <= '0;
            edge_q     <= '0;
            tick_o     <= '0;
            byte_end_o <= 1'b0;
        end else begin
            // Strobes registered, first edge lands CLK_DIV cycles after run
            tick_o.rise <= half_end && !edge_q[0];
            tick_o.fall <= half_end && edge_q[0];
            byte_end_o  <= half_end && (edge_q == 4'd15);

            if (!run_i || byte_end_o) begin
                half_q <= '0;                       // Idle or byte finished
                edge_q <= '0;
            end else if (half_end) begin
                half_q <= '0;
                edge_q <= edge_q + 4'd1;            // Wraps after 16 edges
            end else begin
                half_q <= half_q + CNT_W'(1);
            end
        end
    end

    // Edges alternate, never both at once
    a_tick_excl : assert property (
        @(posedge sysClk) disable iff (!reset) !(tick_o.rise && tick_o.fall)
    ) else $error("rise and fall in the same cycle");

endmodule

/* spi_shifter.sv */
module spi_shifter (
    input  logic                  sysClk,
    input  logic                  reset,       // Sync, active low
    input  logic                  load_i,      // Take tx_byte_i
    input  spi_io_pkg::byte_t     tx_byte_i,   // Byte to send
    input  spi_io_pkg::spi_tick_t tick_i,      // Edge strobes from the timer
    input  logic                  miso_i,
    output logic                  sclk_o,
    output logic                  mosi_o,
    output spi_io_pkg::byte_t     rx_byte_o    // Complete on byte_end
);

    // --------------------
    // Transmit side
    // --------------------
    spi_io_pkg::byte_t tx_sr;   // MSB is on the pin

    always_ff @(posedge sysClk) begin
        if (!reset) begin
            tx_sr <= '0;                            // mosi low out of reset
        end else if (load_i) begin
            tx_sr <= tx_byte_i;                     // MSB out on the next cycle
        end else if (tick_i.fall) begin
            tx_sr <= {tx_sr[6:0], 1'b0};            // Next bit after falling edge
        end
    end

    assign mosi_o = tx_sr[7];

    // --------------------
    // Clock pin
    // --------------------
    // Mode 0, idles low and stays high between rise and fall
    always_ff @(posedge sysClk) begin
        if (!reset) begin
            sclk_o <= 1'b0;
        end else if (tick_i.rise) begin
            sclk_o <= 1'b1;
        end else if (tick_i.fall) begin
            sclk_o <= 1'b0;
        end
    end

    // --------------------
    // Receive side
    // --------------------
    spi_io_pkg::byte_t rx_sr;   // MSB first, shifts in from the bottom

    always_ff @(posedge sysClk) begin
        if (tick_i.rise) begin
            rx_sr <= {rx_sr[6:0], miso_i};          // Sample on the rising strobe
        end
    end

    assign rx_byte_o = rx_sr;

endmodule

/* spi_io_fsm.sv */
module spi_io_fsm #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                                                 sysClk,
    input  logic                                                 reset,      // Sync, active low
    input  logic                                                 send_n_i,   // Start request
    input  logic                                                 tx_wr_n_i,  // Host byte write
    input  logic                                                 byte_end_i,
    input  spi_io_pkg::byte_t                                    rx_byte_i,
    output logic                                                 tx_rd_n_o,
    output logic [((BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1)-1:0] tx_addr_o,
    output logic                                                 rx_wr_n_o,
    output logic [((BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1)-1:0] rx_addr_o,
    output spi_io_pkg::byte_t                                    rx_data_o,
    output logic                                                 load_o,     // Shifter load
    output logic                                                 run_o,      // Timer enable
    output logic                                                 cs_n_o,
    output logic                                                 busy_o,
    output logic                                                 done_o
);

    localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CW = $clog2(BUF_DEPTH + 1);     // Count runs 0..BUF_DEPTH

    spi_io_pkg::io_state_e state_q, state_d;

    logic [CW-1:0] cnt_q;       // Pending bytes
    logic [AW-1:0] idx_q;       // Byte being shifted
    logic          accept;      // Send taken this cycle
    logic          last_byte;   // idx at count - 1

    assign accept    = (state_q == spi_io_pkg::IDLE) && !send_n_i;
    assign last_byte = (CW'(idx_q) == (cnt_q - CW'(1)));

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            spi_io_pkg::IDLE: begin
                if (accept) begin
                    // Nothing pending goes straight to the end pulse
                    state_d = (cnt_q == '0) ? spi_io_pkg::DONE : spi_io_pkg::LOAD;
                end
            end
            spi_io_pkg::LOAD:  state_d = spi_io_pkg::SHIFT;
            spi_io_pkg::SHIFT: begin
                if (byte_end_i) begin
                    state_d = last_byte ? spi_io_pkg::DONE : spi_io_pkg::NEXT;
                end
            end
            spi_io_pkg::NEXT:  state_d = spi_io_pkg::SHIFT;
            spi_io_pkg::DONE:  state_d = spi_io_pkg::IDLE;
            default:           state_d = spi_io_pkg::IDLE;
        endcase
    end

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge sysClk) begin
        if (!reset) begin
            state_q   <= spi_io_pkg::IDLE;
            cnt_q     <= '0;
            idx_q     <= '0;
            cs_n_o    <= 1'b1;
            rx_wr_n_o <= 1'b1;
        end else begin
            state_q <= state_d;
            // Chip select low from LOAD through the last SHIFT
            cs_n_o  <= !((state_d == spi_io_pkg::LOAD) || (state_d == spi_io_pkg::SHIFT) ||
                         (state_d == spi_io_pkg::NEXT));
            // Received byte written one cycle after byte_end
            rx_wr_n_o <= !((state_q == spi_io_pkg::SHIFT) && byte_end_i);

            // Host writes count only while idle and not on a send cycle
            if (state_q == spi_io_pkg::DONE) begin
                cnt_q <= '0;
            end else if ((state_q == spi_io_pkg::IDLE) && !tx_wr_n_i && send_n_i &&
                         (cnt_q != CW'(BUF_DEPTH))) begin
                cnt_q <= cnt_q + CW'(1);            // Saturates at BUF_DEPTH
            end

            if (state_q == spi_io_pkg::IDLE) begin
                idx_q <= '0;
            end else if ((state_q == spi_io_pkg::SHIFT) && byte_end_i) begin
                idx_q <= idx_q + AW'(1);
            end
        end
    end

    // Payload of the receive write, no reset
    always_ff @(posedge sysClk) begin
        if ((state_q == spi_io_pkg::SHIFT) && byte_end_i) begin
            rx_addr_o <= idx_q;
            rx_data_o <= rx_byte_i;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    // Fetch one state ahead of the load: on accept, and on each non-final byte_end
    assign tx_rd_n_o = !((accept && (cnt_q != '0)) ||
                         ((state_q == spi_io_pkg::SHIFT) && byte_end_i && !last_byte));
    assign tx_addr_o = (state_q == spi_io_pkg::IDLE) ? '0 : (idx_q + AW'(1));
    assign load_o    = (state_q == spi_io_pkg::LOAD) || (state_q == spi_io_pkg::NEXT);
    assign run_o     = (state_q == spi_io_pkg::SHIFT);
    assign busy_o    = (state_q != spi_io_pkg::IDLE);   // Covers the final rx write in DONE
    assign done_o    = (state_q == spi_io_pkg::DONE);

    // Slave stays selected while bits move
    a_cs_in_shift : assert property (
        @(posedge sysClk) disable iff (!reset) (state_q == spi_io_pkg::SHIFT) |-> !cs_n_o
    ) else $error("cs_n high during SHIFT");

    // End pulse lasts one cycle
    a_done_pulse : assert property (
        @(posedge sysClk) disable iff (!reset) done_o |=> !done_o
    ) else $error("done_o held for two cycles");

endmodule

/* spi_io_top.sv */
module spi_io_top #(
    parameter int CLK_DIV   = 2,    // sysClk cycles per SPI half-period
    parameter int BUF_DEPTH = 8     // Bytes per buffer
) (
    input  logic                                                 sysClk,
    input  logic                                                 reset,      // Sync, active low
    input  logic                                                 send_n_i,
    input  logic                                                 tx_wr_n_i,
    input  logic [((BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1)-1:0] tx_addr_i,
    input  spi_io_pkg::byte_t                                    tx_data_i,
    input  logic                                                 rx_rd_n_i,
    input  logic [((BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1)-1:0] rx_addr_i,
    output spi_io_pkg::byte_t                                    rx_data_o,
    output logic                                                 busy_o,
    output logic                                                 done_o,
    output spi_io_pkg::spi_pins_t                                spi_o,
    input  logic                                                 miso_i
);

    localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

    logic                  fsm_tx_rd_n, fsm_rx_wr_n;
    logic [AW-1:0]         fsm_tx_addr, fsm_rx_addr;
    spi_io_pkg::byte_t     fsm_rx_data;
    spi_io_pkg::byte_t     tx_rd_data;      // Byte headed for the shifter
    spi_io_pkg::byte_t     rx_byte;         // Byte assembled by the shifter
    logic                  load, run, cs_n, sclk, mosi, byte_end;
    spi_io_pkg::spi_tick_t tick;

    // --------------------
    // Buffer address muxes
    // --------------------
    logic          tx_fsm_sel;
    logic [AW-1:0] tx_buf_addr, rx_buf_addr;
    logic          tx_buf_wr_n, rx_buf_rd_n;

    assign tx_fsm_sel  = busy_o || !fsm_tx_rd_n;            // FSM fetch owns the port
    assign tx_buf_addr = tx_fsm_sel ? fsm_tx_addr : tx_addr_i;
    assign tx_buf_wr_n = tx_wr_n_i || busy_o || !send_n_i;  // Dropped while busy or on send
    assign rx_buf_addr = busy_o ? fsm_rx_addr : rx_addr_i;
    assign rx_buf_rd_n = rx_rd_n_i || busy_o;               // Host reads ignored mid-transfer

    spi_io_buffer #(.BUF_DEPTH(BUF_DEPTH)) tx_buf (
        .sysClk (sysClk),
        .wr_n_i (tx_buf_wr_n),
        .rd_n_i (fsm_tx_rd_n),
        .addr_i (tx_buf_addr),
        .data_i (tx_data_i),
        .data_o (tx_rd_data)
    );

    spi_io_buffer #(.BUF_DEPTH(BUF_DEPTH)) rx_buf (
        .sysClk (sysClk),
        .wr_n_i (fsm_rx_wr_n),
        .rd_n_i (rx_buf_rd_n),
        .addr_i (rx_buf_addr),
        .data_i (fsm_rx_data),
        .data_o (rx_data_o)
    );

    // --------------------
    // SPI engine
    // --------------------
    spi_clk_timer #(.CLK_DIV(CLK_DIV)) u_timer (
        .sysClk     (sysClk),
        .reset      (reset),
        .run_i      (run),
        .tick_o     (tick),
        .byte_end_o (byte_end)
    );

    spi_shifter u_shifter (
        .sysClk    (sysClk),
        .reset     (reset),
        .load_i    (load),
        .tx_byte_i (tx_rd_data),
        .tick_i    (tick),
        .miso_i    (miso_i),
        .sclk_o    (sclk),
        .mosi_o    (mosi),
        .rx_byte_o (rx_byte)
    );

    spi_io_fsm #(.BUF_DEPTH(BUF_DEPTH)) u_fsm (
        .sysClk     (sysClk),
        .reset      (reset),
        .send_n_i   (send_n_i),
        .tx_wr_n_i  (tx_wr_n_i),
        .byte_end_i (byte_end),
        .rx_byte_i  (rx_byte),
        .tx_rd_n_o  (fsm_tx_rd_n),
        .tx_addr_o  (fsm_tx_addr),
        .rx_wr_n_o  (fsm_rx_wr_n),
        .rx_addr_o  (fsm_rx_addr),
        .rx_data_o  (fsm_rx_data),
        .load_o     (load),
        .run_o      (run),
        .cs_n_o     (cs_n),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    // Pins out as one bundle
    assign spi_o = '{sclk: sclk, mosi: mosi, cs_n: cs_n};

endmodule

/* spi_slave_model.sv */
module spi_slave_model (
    input  spi_io_pkg::spi_pins_t spi_i,
    output logic                  miso_o,
    output int                    rise_cnt_o,    // Running count of selected sclk rises
    output int                    sel_cnt_o,     // Running count of cs_n falls
    output int                    stray_cnt_o    // sclk rises seen with cs_n high
);
    timeunit 1ns;
    timeprecision 100ps;

    logic              sclk, mosi, cs_n;
    spi_io_pkg::byte_t in_sr  = '0;      // Bits from the master
    spi_io_pkg::byte_t out_sr = 8'h3C;   // Reply, MSB on miso
    logic [2:0]        bit_q  = '0;      // Wraps to zero after each byte
    int                rises  = 0;
    int                sels   = 0;
    int                strays = 0;

    assign sclk        = spi_i.sclk;
    assign mosi        = spi_i.mosi;
    assign cs_n        = spi_i.cs_n;
    assign miso_o      = out_sr[7];
    assign rise_cnt_o  = rises;
    assign sel_cnt_o   = sels;
    assign stray_cnt_o = strays;

    // Mode 0, mosi sampled on the rising edge
    always @(posedge sclk) begin
        if (cs_n === 1'b0) begin
            in_sr <= {in_sr[6:0], mosi};
            bit_q <= bit_q + 3'd1;
            rises <= rises + 1;
        end else begin
            strays <= strays + 1;        // Clock without a select
        end
    end

    // Reply moves on the falling edge, preamble again after deselect
    always @(negedge sclk or posedge cs_n) begin
        if (cs_n === 1'b1) begin
            out_sr <= 8'h3C;
        end else if (cs_n === 1'b0) begin
            if (bit_q == 3'd0) begin
                out_sr <= ~in_sr;        // Echo of the byte just taken, inverted
            end else begin
                out_sr <= {out_sr[6:0], 1'b0};
            end
        end
    end

    always @(negedge cs_n) sels <= sels + 1;

endmodule

/* tb_spi_io.sv */
module tb_spi_io;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_DIV     = 2;
    localparam int BUF_DEPTH   = 8;
    localparam int AW          = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int SEED        = 96875;
    localparam int SHORT_LEN   = 3;                   // Short transfer
    localparam int BUSY_LEN    = 5;                   // Transfer hit by writes while busy
    localparam int AFTER_LEN   = 2;                   // Transfer right after it
    localparam int BYTE_CYC    = 16 * CLK_DIV + 4;    // Worst case per byte with NEXT
    localparam int TOTAL_BYTES = BUF_DEPTH + SHORT_LEN + BUSY_LEN + AFTER_LEN;
    localparam int TIMEOUT_CYC = TOTAL_BYTES * BYTE_CYC + 1500;  // Margin for reset and reads
    localparam spi_io_pkg::spi_pins_t IDLE_PINS = '{sclk: 1'b0, mosi: 1'b0, cs_n: 1'b1};

    logic                  sysClk, reset, send_n, tx_wr_n, rx_rd_n, miso, busy, done;
    logic [AW-1:0]         tx_addr, rx_addr;
    spi_io_pkg::byte_t     tx_data, rx_data;
    spi_io_pkg::spi_pins_t spi;
    int                    rise_total, sel_total, stray_total;

    spi_io_pkg::byte_t tx_model [BUF_DEPTH];   // Bytes of the current transfer
    spi_io_pkg::byte_t rx_model [BUF_DEPTH];   // Expected receive buffer
    string             cur_test;
    int                checks, errors, err_base, rise0, sel0, stray0, done0;
    int                byte_checks = 0;
    int                byte_errs   = 0;
    int                done_seen   = 0;
    logic              rd_pend     = 1'b0;
    logic [AW-1:0]     rd_addr_q;

    spi_io_top #(.CLK_DIV(CLK_DIV), .BUF_DEPTH(BUF_DEPTH)) dut (
        .sysClk    (sysClk),
        .reset     (reset),
        .send_n_i  (send_n),
        .tx_wr_n_i (tx_wr_n),
        .tx_addr_i (tx_addr),
        .tx_data_i (tx_data),
        .rx_rd_n_i (rx_rd_n),
        .rx_addr_i (rx_addr),
        .rx_data_o (rx_data),
        .busy_o    (busy),
        .done_o    (done),
        .spi_o     (spi),
        .miso_i    (miso)
    );

    spi_slave_model slave (
        .spi_i       (spi),
        .miso_o      (miso),
        .rise_cnt_o  (rise_total),
        .sel_cnt_o   (sel_total),
        .stray_cnt_o (stray_total)
    );

    always #2 sysClk = ~sysClk;   // 4 ns period

    // Byte k back from the slave: fixed preamble first, then the inverse of byte k-1
    function automatic spi_io_pkg::byte_t ref_reply(int k, spi_io_pkg::byte_t prev_tx);
        if (k == 0) begin
            return 8'h3C;
        end
        return ~prev_tx;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_byte(string name, spi_io_pkg::byte_t exp, spi_io_pkg::byte_t act);
        byte_checks++;
        if (act !== exp) begin
            byte_errs++;
            $display("FAILED %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_pins(string name, spi_io_pkg::spi_pins_t exp,
                              spi_io_pkg::spi_pins_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected sclk/mosi/cs_n %03b, actual %03b", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, bit exp, bit act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // --------------------
    // Host side drivers
    // --------------------
    task automatic write_tx(logic [AW-1:0] addr, spi_io_pkg::byte_t data);
        @(posedge sysClk);
        tx_addr <= addr;
        tx_data <= data;
        tx_wr_n <= 1'b0;
        @(posedge sysClk);
        tx_wr_n <= 1'b1;
    endtask

    task automatic read_rx(logic [AW-1:0] addr);
        @(posedge sysClk);
        rx_addr <= addr;
        rx_rd_n <= 1'b0;
        @(posedge sysClk);
        rx_rd_n <= 1'b1;
    endtask

    task automatic pulse_send();
        @(posedge sysClk);
        send_n <= 1'b0;
        @(posedge sysClk);
        send_n <= 1'b1;
    endtask

    task automatic load_bytes(int n);
        spi_io_pkg::byte_t b;
        for (int k = 0; k < n; k++) begin
            b           = spi_io_pkg::byte_t'($urandom());
            tx_model[k] = b;
            write_tx(AW'(k), b);       // Address follows the pending count
        end
    endtask

    task automatic readback();
        for (int a = 0; a < BUF_DEPTH; a++) begin
            read_rx(AW'(a));
        end
        repeat (2) @(negedge sysClk);  // Last compare lands here
    endtask

    task automatic wait_done(int max_cyc);
        int n;
        n = 0;
        do begin
            @(negedge sysClk);
            n++;
        end while ((done !== 1'b1) && (n < max_cyc));
        if (done !== 1'b1) begin
            errors++;
            $display("%s: no done_o pulse within %0d cycles", cur_test, max_cyc);
        end
    endtask

    task automatic start_transfer();
        @(negedge sysClk);
        rise0  = rise_total;           // Baselines for this transfer
        sel0   = sel_total;
        stray0 = stray_total;
        done0  = done_seen;
        pulse_send();
    endtask

    task automatic finish_transfer(int n);
        wait_done(n * BYTE_CYC + 8);
        repeat (4) @(negedge sysClk);  // Final rx write and cs_n settle
        check_count({cur_test, " done pulses"}, 1, done_seen - done0);
        check_count({cur_test, " sclk rises"}, 8 * n, rise_total - rise0);
        check_count({cur_test, " cs_n falls"}, (n > 0) ? 1 : 0, sel_total - sel0);
        check_count({cur_test, " stray sclk"}, 0, stray_total - stray0);
        check_flag({cur_test, " busy"}, 1'b0, busy);
        check_pins({cur_test, " idle pins"}, IDLE_PINS, spi);
        for (int k = 0; k < n; k++) begin
            rx_model[k] = ref_reply(k, (k > 0) ? tx_model[k-1] : 8'h00);
        end
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        err_base = errors + byte_errs;
    endtask

    task automatic end_test();
        int n;
        n = errors + byte_errs - err_base;
        if (n == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, n);
        end
    endtask

    // done_o counted on every falling edge
    always @(negedge sysClk) begin
        if (done) begin
            done_seen <= done_seen + 1;
        end
    end

    // Read data compared one cycle after the strobe
    always @(negedge sysClk) begin
        if (rd_pend) begin
            check_byte($sformatf("%s rx[%0d]", cur_test, rd_addr_q), rx_model[rd_addr_q], rx_data);
        end
        rd_pend   <= !rx_rd_n;
        rd_addr_q <= rx_addr;
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        sysClk  = 1'b0;
        reset   = 1'b0;
        send_n  = 1'b1;
        tx_wr_n = 1'b1;
        rx_rd_n = 1'b1;
        tx_addr = '0;
        rx_addr = '0;
        tx_data = '0;
        checks  = 0;
        errors  = 0;
        for (int a = 0; a < BUF_DEPTH; a++) begin
            rx_model[a] = '0;
        end
        void'($urandom(SEED));
        repeat (16) @(posedge sysClk);
        reset <= 1'b1;

        begin_test("reset");
        @(negedge sysClk);
        check_pins("reset pins", IDLE_PINS, spi);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        end_test();

        begin_test("full");
        load_bytes(BUF_DEPTH);
        start_transfer();
        finish_transfer(BUF_DEPTH);
        readback();
        end_test();

        begin_test("short");               // Upper addresses keep the full-transfer bytes
        load_bytes(SHORT_LEN);
        start_transfer();
        finish_transfer(SHORT_LEN);
        readback();
        end_test();

        begin_test("busy");
        load_bytes(BUSY_LEN);
        start_transfer();
        @(negedge sysClk);
        check_flag("busy after send", 1'b1, busy);
        pulse_send();                      // Second send mid-transfer
        for (int a = 0; a < BUF_DEPTH; a++) begin
            write_tx(AW'(a), ~tx_model[a]); // Would corrupt bytes not yet fetched
        end
        finish_transfer(BUSY_LEN);
        readback();
        load_bytes(AFTER_LEN);
        start_transfer();
        finish_transfer(AFTER_LEN);
        readback();
        end_test();

        begin_test("empty");
        start_transfer();
        finish_transfer(0);
        end_test();

        $display("%0d checks, %0d errors", checks + byte_checks, errors + byte_errs);
        if ((errors + byte_errs) == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge sysClk);
        $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* spi_io_top.f */
spi_io_pkg.sv
spi_io_buffer.sv
spi_clk_timer.sv
spi_shifter.sv
spi_io_fsm.sv
spi_io_top.sv
spi_slave_model.sv
tb_spi_io.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= spi_io_top.f
TOP       ?= tb_spi_io
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
